// File: common/ahb_lite_pkg.sv
package ahb_lite_pkg;

	// ------------------------------------------------------------
	// Bus widths and transfer encodings
	// ------------------------------------------------------------
	localparam int AHB_AW = 32;
	localparam int AHB_DW = 32;

	typedef enum logic [1:0] {
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htrans_e;

	typedef struct packed {
		logic [AHB_AW-1:0] haddr;
		htrans_e           htrans;
		logic              hwrite;
		logic [2:0]        hsize;   // 0 byte, 1 half, 2 word
		logic [AHB_DW-1:0] hwdata;  // Valid in data phase
	} ahb_req_t;

	typedef struct packed {
		logic [AHB_DW-1:0] hrdata;
		logic              hreadyout;
		logic              hresp;  // 1 = ERROR
	} ahb_rsp_t;

	typedef enum logic [1:0] {
		SEL_SRAM,
		SEL_GPIO,
		SEL_NONE
	} slave_sel_e;

	// ------------------------------------------------------------
	// Memory map, decoded on address bits 31:28
	// ------------------------------------------------------------
	localparam logic [3:0] SRAM_REGION = 4'h2;
	localparam logic [3:0] GPIO_REGION = 4'h4;

	// GPIO register byte offsets
	localparam int GPIO_OFS_W = 5;
	localparam logic [GPIO_OFS_W-1:0] GPIO_DATA_OFS    = 5'h00;
	localparam logic [GPIO_OFS_W-1:0] GPIO_DOUT_OFS    = 5'h04;
	localparam logic [GPIO_OFS_W-1:0] GPIO_OUTEN_OFS   = 5'h08;
	localparam logic [GPIO_OFS_W-1:0] GPIO_INTEN_OFS   = 5'h0C;
	localparam logic [GPIO_OFS_W-1:0] GPIO_INTSTAT_OFS = 5'h10;

	localparam int GPIO_PINS = 16;

	// NONSEQ and SEQ carry a real transfer
	function automatic logic trans_active(htrans_e t);
		return (t == NONSEQ) || (t == SEQ);
	endfunction

endpackage

// File: hw/ahb_interconnect.sv
module ahb_interconnect import ahb_lite_pkg::*; (
	input  logic     hclk_i,
	input  logic     arst_n_i,
	input  ahb_req_t ahb_req_i,
	output logic     sram_sel_o,
	output logic     gpio_sel_o,
	output logic     hready_o,
	input  ahb_rsp_t sram_rsp_i,
	input  ahb_rsp_t gpio_rsp_i,
	output ahb_rsp_t ahb_rsp_o
);

	typedef enum logic {
		DEF_OKAY,
		DEF_ERROR
	} def_state_e;

	slave_sel_e sel_dec;      // Target of current address phase
	slave_sel_e dsel_q;       // Target owning the data phase
	def_state_e def_state_q;
	logic       def_rdy_q;    // Low only in first ERROR cycle
	logic       addr_accept;
	ahb_rsp_t   def_rsp;

	// ------------------------------------------------------------
	// Address decode
	// ------------------------------------------------------------
	always_comb begin
		case (ahb_req_i.haddr[AHB_AW-1 -: 4])
			SRAM_REGION: sel_dec = SEL_SRAM;
			GPIO_REGION: sel_dec = SEL_GPIO;
			default:     sel_dec = SEL_NONE;
		endcase
	end

	assign sram_sel_o  = (sel_dec == SEL_SRAM);
	assign gpio_sel_o  = (sel_dec == SEL_GPIO);
	assign addr_accept = hready_o && trans_active(ahb_req_i.htrans);

	always_ff @(posedge hclk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			dsel_q <= SEL_NONE;
		end else if (hready_o) begin
			dsel_q <= sel_dec;  // IDLE/BUSY also move it, targets answer OKAY
		end
	end

	// ------------------------------------------------------------
	// Default slave, two-cycle ERROR for unmapped regions
	// ------------------------------------------------------------
	always_ff @(posedge hclk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			def_state_q <= DEF_OKAY;
			def_rdy_q   <= 1'b1;
		end else if (addr_accept && sel_dec == SEL_NONE) begin
			def_state_q <= DEF_ERROR;
			def_rdy_q   <= 1'b0;
		end else if (def_state_q == DEF_ERROR && !def_rdy_q) begin
			def_rdy_q   <= 1'b1;  // Second ERROR cycle
		end else begin
			def_state_q <= DEF_OKAY;
		end
	end

	assign def_rsp.hrdata    = '0;
	assign def_rsp.hreadyout = def_rdy_q;
	assign def_rsp.hresp     = (def_state_q == DEF_ERROR);

	// Data-phase response mux
	always_comb begin
		case (dsel_q)
			SEL_SRAM: ahb_rsp_o = sram_rsp_i;
			SEL_GPIO: ahb_rsp_o = gpio_rsp_i;
			default:  ahb_rsp_o = def_rsp;
		endcase
	end

	assign hready_o = ahb_rsp_o.hreadyout;

endmodule

// File: sram/ahb_sram.sv
module ahb_sram import ahb_lite_pkg::*; #(
	parameter int SRAM_AW = 12
) (
	input  logic     hclk_i,
	input  logic     arst_n_i,
	input  logic     sel_i,
	input  logic     hready_i,
	input  ahb_req_t ahb_req_i,
	output ahb_rsp_t rsp_o
);

	localparam int WORDS = 2 ** (SRAM_AW - 2);

	logic [AHB_DW-1:0]    mem [WORDS];
	logic                 accept;
	logic [SRAM_AW-3:0]   addr_idx;
	logic                 wr_pend_q;   // Write data phase in progress
	logic [SRAM_AW-3:0]   wr_addr_q;
	logic [3:0]           wr_be_q;
	logic [AHB_DW-1:0]    rd_word;
	logic [AHB_DW-1:0]    rd_data_q;

	// Lane enables from size and low address bits
	function automatic logic [3:0] byte_en(logic [2:0] size, logic [1:0] ofs);
		case (size)
			3'd0:    return 4'b0001 << ofs;
			3'd1:    return ofs[1] ? 4'b1100 : 4'b0011;
			default: return 4'b1111;
		endcase
	endfunction

	assign accept   = sel_i && hready_i && trans_active(ahb_req_i.htrans);
	assign addr_idx = ahb_req_i.haddr[SRAM_AW-1:2];

	// ------------------------------------------------------------
	// Write address capture
	// ------------------------------------------------------------
	always_ff @(posedge hclk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wr_pend_q <= 1'b0;
		end else if (hready_i) begin
			wr_pend_q <= accept && ahb_req_i.hwrite;
		end
	end

	always_ff @(posedge hclk_i) begin
		if (accept && ahb_req_i.hwrite) begin
			wr_addr_q <= addr_idx;
			wr_be_q   <= byte_en(ahb_req_i.hsize, ahb_req_i.haddr[1:0]);
		end
	end

	// Array update at end of the write data phase
	always_ff @(posedge hclk_i) begin
		if (wr_pend_q && hready_i) begin
			for (int b = 0; b < 4; b++) begin
				if (wr_be_q[b])
					mem[wr_addr_q][8*b +: 8] <= ahb_req_i.hwdata[8*b +: 8];
			end
		end
	end

	// Read with forwarding from the write still in flight
	always_comb begin
		rd_word = mem[addr_idx];
		if (wr_pend_q && wr_addr_q == addr_idx) begin
			for (int b = 0; b < 4; b++) begin
				if (wr_be_q[b])
					rd_word[8*b +: 8] = ahb_req_i.hwdata[8*b +: 8];
			end
		end
	end

	always_ff @(posedge hclk_i) begin
		if (accept && !ahb_req_i.hwrite)
			rd_data_q <= rd_word;
	end

	assign rsp_o.hrdata    = rd_data_q;
	assign rsp_o.hreadyout = 1'b1;  // Zero wait
	assign rsp_o.hresp     = 1'b0;

endmodule

// File: gpio/gpio_in_sync.sv
module gpio_in_sync import ahb_lite_pkg::*; #(
	parameter int NUM_PINS = GPIO_PINS
) (
	input  logic                hclk_i,
	input  logic                arst_n_i,
	input  logic [NUM_PINS-1:0] pin_i,
	output logic [NUM_PINS-1:0] pin_sync_o,
	output logic [NUM_PINS-1:0] rise_o
);

	logic [NUM_PINS-1:0] meta_q;   // First stage, may go metastable
	logic [NUM_PINS-1:0] sync_q;
	logic [NUM_PINS-1:0] prev_q;   // Last value for edge compare

	always_ff @(posedge hclk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			meta_q <= '0;
			sync_q <= '0;
			prev_q <= '0;
		end else begin
			meta_q <= pin_i;
			sync_q <= meta_q;
			prev_q <= sync_q;
		end
	end

	assign pin_sync_o = sync_q;
	assign rise_o     = sync_q & ~prev_q;

endmodule

// File: gpio/ahb_gpio.sv
module ahb_gpio import ahb_lite_pkg::*; #(
	parameter int NUM_PINS = GPIO_PINS
) (
	input  logic                hclk_i,
	input  logic                arst_n_i,
	input  logic                sel_i,
	input  logic                hready_i,
	input  ahb_req_t            ahb_req_i,
	output ahb_rsp_t            rsp_o,
	input  logic [NUM_PINS-1:0] port_in_i,
	output logic [NUM_PINS-1:0] port_out_o,
	output logic [NUM_PINS-1:0] port_en_o,
	output logic [NUM_PINS-1:0] gpio_int_o,
	output logic                irq_o
);

	logic                  accept;
	logic                  wr_pend_q;
	logic [GPIO_OFS_W-1:0] reg_addr_q;   // Offset of data-phase access
	logic                  wr_en;
	logic [NUM_PINS-1:0]   wdata;
	logic [NUM_PINS-1:0]   pin_sync;
	logic [NUM_PINS-1:0]   pin_rise;
	logic [NUM_PINS-1:0]   dout_q;
	logic [NUM_PINS-1:0]   outen_q;
	logic [NUM_PINS-1:0]   inten_q;
	logic [NUM_PINS-1:0]   intstat_q;
	logic [NUM_PINS-1:0]   int_clr;
	logic [NUM_PINS-1:0]   rd_data;

	gpio_in_sync #(.NUM_PINS(NUM_PINS)) u_in_sync (
		.hclk_i     (hclk_i),
		.arst_n_i   (arst_n_i),
		.pin_i      (port_in_i),
		.pin_sync_o (pin_sync),
		.rise_o     (pin_rise)
	);

	assign accept = sel_i && hready_i && trans_active(ahb_req_i.htrans);
	assign wr_en  = wr_pend_q && hready_i;
	assign wdata  = ahb_req_i.hwdata[NUM_PINS-1:0];

	always_ff @(posedge hclk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wr_pend_q  <= 1'b0;
			reg_addr_q <= '0;
		end else if (hready_i) begin
			wr_pend_q  <= accept && ahb_req_i.hwrite;
			reg_addr_q <= ahb_req_i.haddr[GPIO_OFS_W-1:0];
		end
	end

	// ------------------------------------------------------------
	// Registers, written at end of data phase
	// ------------------------------------------------------------
	assign int_clr = (wr_en && reg_addr_q == GPIO_INTSTAT_OFS) ? wdata : '0;

	always_ff @(posedge hclk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			dout_q    <= '0;
			outen_q   <= '0;
			inten_q   <= '0;
			intstat_q <= '0;
		end else begin
			if (wr_en && reg_addr_q == GPIO_DOUT_OFS)  dout_q  <= wdata;
			if (wr_en && reg_addr_q == GPIO_OUTEN_OFS) outen_q <= wdata;
			if (wr_en && reg_addr_q == GPIO_INTEN_OFS) inten_q <= wdata;
			// New edge wins over a clear in the same cycle
			intstat_q <= (intstat_q & ~int_clr) | (pin_rise & inten_q);
		end
	end

	always_comb begin
		case (reg_addr_q)
			GPIO_DATA_OFS:    rd_data = pin_sync;
			GPIO_DOUT_OFS:    rd_data = dout_q;
			GPIO_OUTEN_OFS:   rd_data = outen_q;
			GPIO_INTEN_OFS:   rd_data = inten_q;
			GPIO_INTSTAT_OFS: rd_data = intstat_q;
			default:          rd_data = '0;
		endcase
	end

	assign rsp_o.hrdata    = AHB_DW'(rd_data);
	assign rsp_o.hreadyout = 1'b1;
	assign rsp_o.hresp     = 1'b0;

	assign port_out_o = dout_q;
	assign port_en_o  = outen_q;
	assign gpio_int_o = intstat_q & inten_q;
	assign irq_o      = |gpio_int_o;  // Combined interrupt

endmodule

// File: hw/ahb_subsystem_top.sv
module ahb_subsystem_top import ahb_lite_pkg::*; #(
	parameter int SRAM_AW  = 12,
	parameter int NUM_PINS = GPIO_PINS
) (
	input  logic                hclk_i,
	input  logic                arst_n_i,
	input  ahb_req_t            ahb_req_i,
	output ahb_rsp_t            ahb_rsp_o,
	input  logic [NUM_PINS-1:0] port_in_i,
	output logic [NUM_PINS-1:0] port_out_o,
	output logic [NUM_PINS-1:0] port_en_o,
	output logic [NUM_PINS-1:0] gpio_int_o,
	output logic                irq_o
);

	logic     sram_sel;
	logic     gpio_sel;
	logic     hready;     // Fed back to every slave
	ahb_rsp_t sram_rsp;
	ahb_rsp_t gpio_rsp;

	ahb_interconnect u_interconnect (
		.hclk_i     (hclk_i),
		.arst_n_i   (arst_n_i),
		.ahb_req_i  (ahb_req_i),
		.sram_sel_o (sram_sel),
		.gpio_sel_o (gpio_sel),
		.hready_o   (hready),
		.sram_rsp_i (sram_rsp),
		.gpio_rsp_i (gpio_rsp),
		.ahb_rsp_o  (ahb_rsp_o)
	);

	ahb_sram #(.SRAM_AW(SRAM_AW)) u_sram (
		.hclk_i    (hclk_i),
		.arst_n_i  (arst_n_i),
		.sel_i     (sram_sel),
		.hready_i  (hready),
		.ahb_req_i (ahb_req_i),
		.rsp_o     (sram_rsp)
	);

	ahb_gpio #(.NUM_PINS(NUM_PINS)) u_gpio (
		.hclk_i     (hclk_i),
		.arst_n_i   (arst_n_i),
		.sel_i      (gpio_sel),
		.hready_i   (hready),
		.ahb_req_i  (ahb_req_i),
		.rsp_o      (gpio_rsp),
		.port_in_i  (port_in_i),
		.port_out_o (port_out_o),
		.port_en_o  (port_en_o),
		.gpio_int_o (gpio_int_o),
		.irq_o      (irq_o)
	);

endmodule

// File: verification/tb_clkgen.sv
module tb_clkgen #(
	parameter int PERIOD     = 4,
	parameter int RST_CYCLES = 16
) (
	output logic clk_o,
	output logic arst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD / 2) clk_o = ~clk_o;
	end

	initial begin
		arst_n_o = 1'b0;
		repeat (RST_CYCLES) @(posedge clk_o);
		#1 arst_n_o = 1'b1;  // Release just after an edge
	end

endmodule

// File: verification/ahb_subsystem_sva.sv
module ahb_subsystem_sva import ahb_lite_pkg::*; #(
	parameter int SRAM_AW  = 12,
	parameter int NUM_PINS = GPIO_PINS
) (
	input logic                hclk_i,
	input logic                arst_n_i,
	input ahb_req_t            ahb_req_i,
	input ahb_rsp_t            ahb_rsp_o,
	input logic [NUM_PINS-1:0] port_in_i,
	input logic [NUM_PINS-1:0] port_out_o,
	input logic [NUM_PINS-1:0] port_en_o,
	input logic [NUM_PINS-1:0] gpio_int_o,
	input logic                irq_o
);

	localparam int WORDS = 2 ** (SRAM_AW - 2);

	int                  failures = 0;  // Read by the testbench top
	logic                hready;
	logic                addr_acc;
	logic [3:0]          region;
	logic                dp_valid;      // Data phase of a real transfer
	logic                dp_write;
	logic [3:0]          dp_region;
	logic [4:0]          dp_ofs;
	logic [SRAM_AW-3:0]  dp_idx;
	logic                sram_wr_done;
	logic                sram_rd_done;
	logic                gpio_wr_done;
	logic                gpio_rd_done;
	logic [AHB_DW-1:0]   shadow [WORDS];  // Reference copy of the SRAM
	logic [WORDS-1:0]    known;
	logic [NUM_PINS-1:0] inten_q;
	logic [NUM_PINS-1:0] dout_exp;
	logic [NUM_PINS-1:0] outen_exp;
	logic [AHB_DW-1:0]   exp_word;

	assign hready   = ahb_rsp_o.hreadyout;
	assign region   = ahb_req_i.haddr[31:28];
	assign addr_acc = hready && (ahb_req_i.htrans == NONSEQ || ahb_req_i.htrans == SEQ);

	always_ff @(posedge hclk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			dp_valid  <= 1'b0;
			dp_write  <= 1'b0;
			dp_region <= '0;
			dp_ofs    <= '0;
			dp_idx    <= '0;
		end else if (hready) begin
			dp_valid  <= addr_acc;
			dp_write  <= ahb_req_i.hwrite;
			dp_region <= region;
			dp_ofs    <= ahb_req_i.haddr[4:0];
			dp_idx    <= ahb_req_i.haddr[SRAM_AW-1:2];
		end
	end

	assign sram_wr_done = dp_valid && hready && dp_write && dp_region == SRAM_REGION;
	assign sram_rd_done = dp_valid && hready && !dp_write && dp_region == SRAM_REGION;
	assign gpio_wr_done = dp_valid && hready && dp_write && dp_region == GPIO_REGION;
	assign gpio_rd_done = dp_valid && hready && !dp_write && dp_region == GPIO_REGION;

	// ------------------------------------------------------------
	// Reference state built from completed writes
	// ------------------------------------------------------------
	always_ff @(posedge hclk_i) begin
		if (sram_wr_done)
			shadow[dp_idx] <= ahb_req_i.hwdata;  // Word writes only
	end

	always_ff @(posedge hclk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			known     <= '0;
			inten_q   <= '0;
			dout_exp  <= '0;
			outen_exp <= '0;
		end else begin
			if (sram_wr_done)
				known[dp_idx] <= 1'b1;
			if (gpio_wr_done && dp_ofs == GPIO_INTEN_OFS)
				inten_q <= ahb_req_i.hwdata[NUM_PINS-1:0];
			if (gpio_wr_done && dp_ofs == GPIO_DOUT_OFS)
				dout_exp <= ahb_req_i.hwdata[NUM_PINS-1:0];
			if (gpio_wr_done && dp_ofs == GPIO_OUTEN_OFS)
				outen_exp <= ahb_req_i.hwdata[NUM_PINS-1:0];
		end
	end

	assign exp_word = shadow[dp_idx];

	// ------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------
	a_reset: assert property (@(posedge hclk_i) $rose(arst_n_i) |->
		(hready && !ahb_rsp_o.hresp && port_en_o == '0 && port_out_o == '0 && !irq_o))
		else begin failures++; $error("outputs not at reset values after reset"); end

	a_sram_rd: assert property (@(posedge hclk_i) disable iff (!arst_n_i)
		(sram_rd_done && known[dp_idx]) |-> ahb_rsp_o.hrdata == exp_word)
		else begin
			failures++;
			$error("CHECK FAILED t=%0t hrdata got %h exp %h", $time,
				ahb_rsp_o.hrdata, exp_word);
		end

	a_unmapped: assert property (@(posedge hclk_i) disable iff (!arst_n_i)
		(addr_acc && region != SRAM_REGION && region != GPIO_REGION) |=>
		(ahb_rsp_o.hresp && !hready) ##1 (ahb_rsp_o.hresp && hready))
		else begin failures++; $error("unmapped access without two-cycle ERROR"); end

	a_dout: assert property (@(posedge hclk_i) disable iff (!arst_n_i)
		(gpio_wr_done && dp_ofs == GPIO_DOUT_OFS) |=> port_out_o == dout_exp)
		else begin
			failures++;
			$error("CHECK FAILED t=%0t port_out_o got %h exp %h", $time,
				port_out_o, dout_exp);
		end

	a_outen: assert property (@(posedge hclk_i) disable iff (!arst_n_i)
		(gpio_wr_done && dp_ofs == GPIO_OUTEN_OFS) |=> port_en_o == outen_exp)
		else begin
			failures++;
			$error("CHECK FAILED t=%0t port_en_o got %h exp %h", $time,
				port_en_o, outen_exp);
		end

	// Pins stable over the two synchronizer stages
	a_data_rd: assert property (@(posedge hclk_i) disable iff (!arst_n_i)
		(gpio_rd_done && dp_ofs == GPIO_DATA_OFS && port_in_i == $past(port_in_i, 1) &&
		port_in_i == $past(port_in_i, 2)) |-> ahb_rsp_o.hrdata[NUM_PINS-1:0] == port_in_i)
		else begin
			failures++;
			$error("CHECK FAILED t=%0t hrdata got %h exp %h", $time,
				ahb_rsp_o.hrdata[NUM_PINS-1:0], port_in_i);
		end

	a_int_clr: assert property (@(posedge hclk_i) disable iff (!arst_n_i)
		(gpio_wr_done && dp_ofs == GPIO_INTSTAT_OFS) |=>
		(gpio_int_o & $past(ahb_req_i.hwdata[NUM_PINS-1:0])) == '0)
		else begin failures++; $error("interrupt bits not cleared by INTSTAT write"); end

	for (genvar i = 0; i < NUM_PINS; i++) begin : g_pin_irq
		a_rise: assert property (@(posedge hclk_i) disable iff (!arst_n_i)
			($rose(port_in_i[i]) && inten_q[i]) |-> ##3 (gpio_int_o[i] && irq_o))
			else begin failures++; $error("pin %0d edge did not raise its interrupt", i); end
	end

endmodule

bind ahb_subsystem_top ahb_subsystem_sva #(
	.SRAM_AW  (SRAM_AW),
	.NUM_PINS (NUM_PINS)
) u_sva (
	.hclk_i     (hclk_i),
	.arst_n_i   (arst_n_i),
	.ahb_req_i  (ahb_req_i),
	.ahb_rsp_o  (ahb_rsp_o),
	.port_in_i  (port_in_i),
	.port_out_o (port_out_o),
	.port_en_o  (port_en_o),
	.gpio_int_o (gpio_int_o),
	.irq_o      (irq_o)
);

// File: verification/tb_top.sv
module tb_top import ahb_lite_pkg::*; ();

	localparam int NUM_PINS   = 16;
	localparam int SRAM_AW    = 12;
	localparam int PERIOD     = 4;
	localparam int NUM_XFERS  = 20;
	localparam int XFER_LIMIT = 16;  // Cycles before a phase counts as stuck
	localparam int WATCHDOG_T = (NUM_XFERS * 10 + 100) * PERIOD;

	logic                clk;
	logic                arst_n;
	ahb_req_t            req;
	ahb_rsp_t            rsp;
	logic [NUM_PINS-1:0] port_in;
	logic [NUM_PINS-1:0] port_out;
	logic [NUM_PINS-1:0] port_en;
	logic [NUM_PINS-1:0] gpio_int;
	logic                irq;
	int                  timeouts = 0;
	int                  xfer_fails = 0;

	tb_clkgen #(.PERIOD(PERIOD), .RST_CYCLES(16)) u_clkgen (
		.clk_o    (clk),
		.arst_n_o (arst_n)
	);

	ahb_subsystem_top #(.SRAM_AW(SRAM_AW), .NUM_PINS(NUM_PINS)) dut0 (
		.hclk_i     (clk),
		.arst_n_i   (arst_n),
		.ahb_req_i  (req),
		.ahb_rsp_o  (rsp),
		.port_in_i  (port_in),
		.port_out_o (port_out),
		.port_en_o  (port_en),
		.gpio_int_o (gpio_int),
		.irq_o      (irq)
	);

	// ------------------------------------------------------------
	// Bus helpers
	// ------------------------------------------------------------
	function automatic logic [31:0] gpio_addr(logic [4:0] ofs);
		return {GPIO_REGION, 23'h0, ofs};
	endfunction

	// Returns 1 unit after the edge that ends the current phase
	task automatic wait_ready(output logic ok);
		int   n;
		logic rdy;
		n   = 0;
		rdy = 1'b0;
		while (!rdy && n < XFER_LIMIT) begin
			@(negedge clk);
			rdy = rsp.hreadyout;  // Mid-cycle, stable
			@(posedge clk);
			n++;
		end
		#1;
		ok = rdy;
	endtask

	task automatic ahb_single(input logic [31:0] addr, input logic wr, input logic [31:0] data);
		logic ok;
		req.haddr  = addr;
		req.htrans = NONSEQ;
		req.hwrite = wr;
		req.hsize  = 3'd2;
		wait_ready(ok);
		req.htrans = IDLE;
		req.hwdata = data;
		if (ok)
			wait_ready(ok);
		if (!ok) begin
			xfer_fails++;
			$display("ERROR: transfer to %h did not complete at %0t", addr, $time);
		end
	endtask

	// Read overlaps the write data phase
	task automatic sram_write_read_back(input logic [31:0] addr, input logic [31:0] data);
		logic ok;
		logic ok_all;
		req.haddr  = addr;
		req.htrans = NONSEQ;
		req.hwrite = 1'b1;
		req.hsize  = 3'd2;
		wait_ready(ok_all);
		req.hwrite = 1'b0;
		req.hwdata = data;
		wait_ready(ok);
		ok_all     = ok_all && ok;
		req.htrans = IDLE;
		wait_ready(ok);
		if (!(ok_all && ok)) begin
			xfer_fails++;
			$display("ERROR: write and read back at %h did not complete at %0t", addr, $time);
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	// ------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------
	initial begin
		logic [31:0] addrs [4];
		logic [31:0] vals [4];
		void'($urandom(76245));
		req        = '0;
		req.htrans = IDLE;
		port_in    = '0;
		@(posedge arst_n);
		idle_cycles(2);

		for (int i = 0; i < 4; i++) begin
			addrs[i] = 32'h2000_0000 | ($urandom & 32'h0000_0FFC);
			vals[i]  = $urandom;
			ahb_single(addrs[i], 1'b1, vals[i]);
		end
		for (int i = 0; i < 4; i++)
			ahb_single(addrs[i], 1'b0, 32'h0);
		sram_write_read_back(32'h2000_0100, $urandom);

		ahb_single(32'h6000_0000, 1'b0, 32'h0);  // Unmapped
		ahb_single(32'hF000_0010, 1'b1, $urandom);

		ahb_single(gpio_addr(GPIO_DOUT_OFS), 1'b1, $urandom);
		ahb_single(gpio_addr(GPIO_OUTEN_OFS), 1'b1, $urandom);
		idle_cycles(2);

		port_in = NUM_PINS'($urandom);
		idle_cycles(3);
		ahb_single(gpio_addr(GPIO_DATA_OFS), 1'b0, 32'h0);

		port_in = '0;
		idle_cycles(4);
		ahb_single(gpio_addr(GPIO_INTEN_OFS), 1'b1, 32'h0000_FFFF);
		port_in = NUM_PINS'($urandom) | NUM_PINS'(1);
		idle_cycles(6);
		ahb_single(gpio_addr(GPIO_INTSTAT_OFS), 1'b1, 32'h0000_FFFF);
		idle_cycles(4);

		$display("errors: %0d assertion, %0d transfer, %0d timeout",
			dut0.u_sva.failures, xfer_fails, timeouts);
		if (dut0.u_sva.failures == 0 && xfer_fails == 0 && timeouts == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	initial begin
		#(WATCHDOG_T);
		timeouts++;
		$display("ERROR: watchdog expired before the tests finished");
		$display("errors: %0d assertion, %0d transfer, %0d timeout",
			dut0.u_sva.failures, xfer_fails, timeouts);
		$display("** FAIL **");
		$finish;
	end

endmodule

// File: src.f
common/ahb_lite_pkg.sv
hw/ahb_interconnect.sv
sram/ahb_sram.sv
gpio/gpio_in_sync.sv
gpio/ahb_gpio.sv
hw/ahb_subsystem_top.sv
verification/tb_clkgen.sv
verification/ahb_subsystem_sva.sv
verification/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= ** PASS **

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
